// File: verilog/ex_pkg.sv
//*********************************************************************
// Shared widths, opcodes and records of the integer execute stage.
// PC values are word addresses; byte address is PC followed by 2'b00.
// Field order of the packed structs is MSB first as listed.
//*********************************************************************

package ex_pkg;

   // Datapath and index widths
   localparam int DW     = 32;
   localparam int PC_W   = 30;
   localparam int FE_W   = 3;
   localparam int PRF_AW = 6;
   localparam int ROB_AW = 4;
   localparam int BANK_W = 2;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_opc_e;

   // Conditional branches first, then the two jumps
   typedef enum logic [3:0] {
      BRU_NONE,
      BRU_BEQ,
      BRU_BNE,
      BRU_BLT,
      BRU_BLTU,
      BRU_BGE,
      BRU_BGEU,
      BRU_JAL,
      BRU_JALR
   } bru_opc_e;

   // Request from the reservation station
   typedef struct packed {
      alu_opc_e              alu_opc;
      bru_opc_e              bru_opc;
      logic                  lsu_op;
      logic                  epu_op;
      logic [FE_W-1:0]       fe;
      logic                  pred_taken;
      logic [PC_W-1:0]       pred_tgt;
      logic [PC_W-1:0]       pc;
      logic [DW-1:0]         imm;
      logic [DW-1:0]         op1;
      logic [DW-1:0]         op2;
      logic [PRF_AW-1:0]     prd;
      logic                  prd_we;
      logic [ROB_AW-1:0]     rob_id;
      logic [BANK_W-1:0]     rob_bank;
   } ex_req_t;

   // Record toward writeback and the ROB
   typedef struct packed {
      logic [ROB_AW-1:0]     rob_id;
      logic [BANK_W-1:0]     rob_bank;
      logic                  prf_we;
      logic [PRF_AW-1:0]     prf_waddr;
      logic [DW-1:0]         prf_wdata;
      logic                  fls;
      logic                  exc;
      logic [DW-1:0]         opera;
      logic [DW-1:0]         operb;
      logic [PC_W-1:0]       fls_tgt;
   } ex_wb_t;

endpackage

// File: verilog/ex_alu.sv
//*********************************************************************
// Combinational integer ALU, no multiply or divide.
// Shift amount is taken from op2[4:0] only.
//*********************************************************************
`timescale 1ns/100ps

module ex_alu
   import ex_pkg::*;
(
   input  ex_req_t         req,
   output logic [DW-1:0]   alu_result
);

   logic            is_sub;
   logic [DW-1:0]   add_b;
   logic [DW-1:0]   add_sum;
   logic [4:0]      shamt;

   // Subtract is op1 + ~op2 + 1 on the same adder
   assign is_sub  = (req.alu_opc == ALU_SUB);
   assign add_b   = is_sub ? ~req.op2 : req.op2;
   assign add_sum = req.op1 + add_b + {{(DW-1){1'b0}}, is_sub};

   assign shamt = req.op2[4:0];

   always_comb begin
      case (req.alu_opc)
         ALU_ADD: begin
            alu_result = add_sum;
         end
         ALU_SUB: begin
            alu_result = add_sum;
         end
         ALU_AND: begin
            alu_result = req.op1 & req.op2;
         end
         ALU_OR: begin
            alu_result = req.op1 | req.op2;
         end
         ALU_XOR: begin
            alu_result = req.op1 ^ req.op2;
         end
         ALU_SLL: begin
            alu_result = req.op1 << shamt;
         end
         ALU_SRL: begin
            alu_result = req.op1 >> shamt;
         end
         ALU_SRA: begin
            // Sign bit fills from the left
            alu_result = $signed(req.op1) >>> shamt;
         end
         default: begin
            alu_result = add_sum;
         end
      endcase
   end

endmodule

// File: verilog/ex_bru.sv
//*********************************************************************
// Combinational branch resolution.
// Relative targets use imm as a word offset; jalr drops op1[1:0].
// Link value is the byte address of the next instruction.
//*********************************************************************
`timescale 1ns/100ps

module ex_bru
   import ex_pkg::*;
(
   input  ex_req_t           req,
   output logic              taken,
   output logic [PC_W-1:0]   tgt,
   output logic [DW-1:0]     link,
   output logic              link_valid
);

   logic [DW-1:0]     diff;
   logic              carry;
   logic              ovf;
   logic              eq;
   logic              lt;
   logic              ltu;
   logic [PC_W-1:0]   npc;
   logic [PC_W-1:0]   rel_tgt;
   logic              is_jal;
   logic              is_jalr;

   // One subtraction op1 - op2 gives all three compares
   assign {carry, diff} = {1'b0, req.op1} + {1'b0, ~req.op2} + {{DW{1'b0}}, 1'b1};
   assign ovf = (req.op1[DW-1] != req.op2[DW-1]) && (diff[DW-1] != req.op1[DW-1]);
   assign eq  = (diff == '0);
   assign lt  = diff[DW-1] ^ ovf;
   // No carry out means a borrow, so op1 < op2 unsigned
   assign ltu = ~carry;

   assign is_jal  = (req.bru_opc == BRU_JAL);
   assign is_jalr = (req.bru_opc == BRU_JALR);

   assign npc     = req.pc + {{(PC_W-1){1'b0}}, 1'b1};
   assign rel_tgt = req.pc + req.imm[PC_W-1:0];

   assign tgt        = is_jalr ? req.op1[DW-1:2] : rel_tgt;
   assign link       = {npc, 2'b00};
   assign link_valid = is_jal | is_jalr;

   always_comb begin
      case (req.bru_opc)
         BRU_BEQ:  taken = eq;
         BRU_BNE:  taken = ~eq;
         BRU_BLT:  taken = lt;
         BRU_BLTU: taken = ltu;
         BRU_BGE:  taken = ~lt;
         BRU_BGEU: taken = ~ltu;
         BRU_JAL:  taken = 1'b1;
         BRU_JALR: taken = 1'b1;
         default:  taken = 1'b0;
      endcase
   end

   // Equal operands never also compare as less-than
   always_comb begin
      assert (!eq || (!lt && !ltu))
         else $error("branch compare flags disagree on equal operands");
   end

endmodule

// File: verilog/ex_hds_buf.sv
//*********************************************************************
// One-deep valid/ready stage control with bypass ready.
// a_ready is low while flush is high; flush empties the stage.
// The upstream side keeps a_valid low during reset.
//*********************************************************************
`timescale 1ns/100ps

module ex_hds_buf (
   input  logic   clk,
   input  logic   reset,
   input  logic   flush,
   input  logic   a_valid,
   output logic   a_ready,
   output logic   b_valid,
   input  logic   b_ready,
   output logic   p_ce
);

   // Accept when empty or when the held entry leaves this cycle
   assign a_ready = (~b_valid | b_ready) & ~flush;
   assign p_ce    = a_valid & a_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         b_valid <= 1'b0;
      end else if (flush) begin
         b_valid <= 1'b0;
      end else if (p_ce) begin
         b_valid <= 1'b1;
      end else if (b_ready) begin
         b_valid <= 1'b0;
      end
   end

   // Stalled output stays valid until taken or flushed
   a_hold_valid : assert property (
      @(posedge clk) disable iff (reset)
      (b_valid && !b_ready && !flush) |=> b_valid
   ) else $error("b_valid dropped while stalled");

   a_no_load_in_reset : assert property (
      @(posedge clk) reset |-> !p_ce
   ) else $error("stage loaded during reset");

endmodule

// File: verilog/ex_pipe.sv
//*********************************************************************
// Execute stage top: ALU, branch unit, speculation check, wb register.
// Loads, stores and system ops only form opera/operb here and never
// write the register file. fls, exc and prf_we qualify with wb_valid.
//*********************************************************************
`timescale 1ns/100ps

module ex_pipe
   import ex_pkg::*;
(
   input  logic      clk,
   input  logic      reset,
   input  logic      flush,
   input  logic      ex_valid,
   input  ex_req_t   ex_req,
   output logic      ex_ready,
   output logic      wb_valid,
   input  logic      wb_ready,
   output ex_wb_t    wb
);

   logic [DW-1:0]     alu_result;
   logic              br_taken;
   logic [PC_W-1:0]   br_tgt;
   logic [DW-1:0]     br_link;
   logic              br_link_valid;
   logic              p_ce;
   logic              fe_nz;
   logic              se_fail;
   logic [PC_W-1:0]   npc;
   logic [DW-1:0]     agu_sum;
   ex_wb_t            s1;
   ex_wb_t            wb_q;

   ex_alu u_alu (
      .req          (ex_req),
      .alu_result   (alu_result)
   );

   ex_bru u_bru (
      .req          (ex_req),
      .taken        (br_taken),
      .tgt          (br_tgt),
      .link         (br_link),
      .link_valid   (br_link_valid)
   );

   ex_hds_buf u_buf (
      .clk          (clk),
      .reset        (reset),
      .flush        (flush),
      .a_valid      (ex_valid),
      .a_ready      (ex_ready),
      .b_valid      (wb_valid),
      .b_ready      (wb_ready),
      .p_ce         (p_ce)
   );

   assign fe_nz   = |ex_req.fe;
   assign npc     = ex_req.pc + {{(PC_W-1){1'b0}}, 1'b1};
   assign agu_sum = ex_req.op1 + ex_req.imm;

   // Target only matters when the branch is actually taken
   assign se_fail = (br_taken ^ ex_req.pred_taken) |
                    (br_taken & (br_tgt != ex_req.pred_tgt));

   always_comb begin
      s1.rob_id    = ex_req.rob_id;
      s1.rob_bank  = ex_req.rob_bank;
      s1.prf_we    = ex_valid & ex_req.prd_we & ~(ex_req.lsu_op | ex_req.epu_op);
      s1.prf_waddr = ex_req.prd;
      s1.prf_wdata = br_link_valid ? br_link : alu_result;
      s1.fls       = ex_valid & se_fail;
      s1.exc       = ex_valid & fe_nz;
      // Exception handler reads the fetch fault code from opera
      s1.opera     = fe_nz ? {{(DW-FE_W){1'b0}}, ex_req.fe} : agu_sum;
      s1.operb     = ex_req.op2;
      s1.fls_tgt   = br_taken ? br_tgt : npc;
   end

   // Payload loads on p_ce; the three control bits also clear
   always_ff @(posedge clk) begin
      if (p_ce) begin
         wb_q <= s1;
      end
      if (reset || flush) begin
         wb_q.prf_we <= 1'b0;
         wb_q.fls    <= 1'b0;
         wb_q.exc    <= 1'b0;
      end
   end

   always_comb begin
      wb        = wb_q;
      wb.prf_we = wb_q.prf_we & wb_valid;
      wb.fls    = wb_q.fls & wb_valid;
      wb.exc    = wb_q.exc & wb_valid;
   end

endmodule

// File: verification/tb_ex_pipe.sv
//*********************************************************************
// Testbench for the execute stage. Requests come from an LFSR stream.
// Expected records come from a separate model of the stage rules.
// A flushed record is removed from the expected queue.
//*********************************************************************
`timescale 1ns/100ps

module tb_ex_pipe;
   import ex_pkg::*;

   localparam int N_A       = 200;
   localparam int N_B       = 200;
   localparam int N_FL      = 10;
   localparam int TOTAL     = N_A + N_B + 4 * N_FL;
   localparam int TIMEOUT   = 4 * TOTAL + 200;
   localparam logic [31:0] SEED = 32'h2f48f3a7;

   logic      clk = 1'b0;
   logic      reset;
   logic      flush;
   logic      ex_valid;
   ex_req_t   ex_req;
   logic      ex_ready;
   logic      wb_valid;
   logic      wb_ready;
   ex_wb_t    wb;

   logic [31:0]   lfsr_req;
   logic [31:0]   lfsr_rdy;
   logic [1:0]    rdy_mode;
   ex_wb_t        exp_q[$];
   ex_wb_t        prev_wb;
   logic          acc_last = 1'b0;
   logic          hold_last = 1'b0;
   logic          flush_last = 1'b0;
   int            n_sent = 0;
   int            n_done = 0;
   int            n_drop = 0;
   int            cycles = 0;

   ex_pipe UUT (
      .clk        (clk),
      .reset      (reset),
      .flush      (flush),
      .ex_valid   (ex_valid),
      .ex_req     (ex_req),
      .ex_ready   (ex_ready),
      .wb_valid   (wb_valid),
      .wb_ready   (wb_ready),
      .wb         (wb)
   );

   always #2 clk = ~clk;

   task automatic stop_with_failure(input string msg);
      $display("ERROR at %0t: %s", $realtime, msg);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopping on first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         $display("[FAIL] %0t %s got %h expected %h", $realtime, name, got, exp);
         stop_with_failure("value mismatch");
      end
   endtask

   // Fibonacci LFSR, taps 32 22 2 1, one step per bit taken
   function automatic logic [31:0] take_bits(inout logic [31:0] st, input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb = st[31] ^ st[21] ^ st[1] ^ st[0];
         st = {st[30:0], fb};
         v = {v[30:0], st[0]};
      end
      return v;
   endfunction

   function automatic ex_req_t gen_req(inout logic [31:0] st);
      ex_req_t           r;
      logic [3:0]        sel;
      logic [2:0]        ls;
      logic [PC_W-1:0]   guess;
      r = '0;
      r.alu_opc = alu_opc_e'(3'(take_bits(st, 3)));
      sel = 4'(take_bits(st, 4));
      r.bru_opc = (sel < 4'd6) ? BRU_NONE : bru_opc_e'(4'(32'd1 + take_bits(st, 3)));
      r.op1 = take_bits(st, 32);
      // Equal operands now and then so beq and bge see ties
      r.op2 = (take_bits(st, 2) == 32'd0) ? r.op1 : take_bits(st, 32);
      r.imm = take_bits(st, 32);
      r.pc = 30'(take_bits(st, 30));
      r.fe = (take_bits(st, 3) == 32'd0) ? 3'(take_bits(st, 3)) : 3'd0;
      ls = 3'(take_bits(st, 3));
      r.lsu_op = (ls == 3'd0);
      r.epu_op = (ls == 3'd1);
      r.pred_taken = 1'(take_bits(st, 1));
      if (r.bru_opc == BRU_NONE && take_bits(st, 2) != 32'd0) begin
         r.pred_taken = 1'b0;
      end
      guess = (r.bru_opc == BRU_JALR) ? r.op1[DW-1:2] : r.pc + r.imm[PC_W-1:0];
      r.pred_tgt = (take_bits(st, 2) == 32'd0) ? 30'(take_bits(st, 30)) : guess;
      r.prd = 6'(take_bits(st, 6));
      r.prd_we = (take_bits(st, 3) != 32'd0);
      r.rob_id = 4'(take_bits(st, 4));
      r.rob_bank = 2'(take_bits(st, 2));
      return r;
   endfunction

   function automatic ex_wb_t ref_ex(input ex_req_t r);
      logic [DW-1:0]     res;
      logic              tk;
      logic [PC_W-1:0]   tg;
      ex_wb_t            w;
      case (r.alu_opc)
         ALU_ADD: res = r.op1 + r.op2;
         ALU_SUB: res = r.op1 - r.op2;
         ALU_AND: res = r.op1 & r.op2;
         ALU_OR:  res = r.op1 | r.op2;
         ALU_XOR: res = r.op1 ^ r.op2;
         ALU_SLL: res = r.op1 << r.op2[4:0];
         ALU_SRL: res = r.op1 >> r.op2[4:0];
         default: res = $unsigned($signed(r.op1) >>> r.op2[4:0]);
      endcase
      case (r.bru_opc)
         BRU_BEQ:  tk = (r.op1 == r.op2);
         BRU_BNE:  tk = (r.op1 != r.op2);
         BRU_BLT:  tk = ($signed(r.op1) < $signed(r.op2));
         BRU_BLTU: tk = (r.op1 < r.op2);
         BRU_BGE:  tk = ($signed(r.op1) >= $signed(r.op2));
         BRU_BGEU: tk = (r.op1 >= r.op2);
         BRU_JAL:  tk = 1'b1;
         BRU_JALR: tk = 1'b1;
         default:  tk = 1'b0;
      endcase
      tg = (r.bru_opc == BRU_JALR) ? r.op1[DW-1:2] : r.pc + r.imm[PC_W-1:0];
      if (r.bru_opc == BRU_JAL || r.bru_opc == BRU_JALR) begin
         res = {r.pc + 30'd1, 2'b00};
      end
      w.rob_id    = r.rob_id;
      w.rob_bank  = r.rob_bank;
      w.prf_we    = r.prd_we && !r.lsu_op && !r.epu_op;
      w.prf_waddr = r.prd;
      w.prf_wdata = res;
      w.fls       = (tk != r.pred_taken) || (tk && tg != r.pred_tgt);
      w.exc       = (r.fe != 3'd0);
      w.opera     = (r.fe != 3'd0) ? {29'd0, r.fe} : r.op1 + r.imm;
      w.operb     = r.op2;
      w.fls_tgt   = tk ? tg : r.pc + 30'd1;
      return w;
   endfunction

   task automatic compare_rec(input ex_wb_t e);
      check_val("wb.rob_id", 64'(wb.rob_id), 64'(e.rob_id));
      check_val("wb.rob_bank", 64'(wb.rob_bank), 64'(e.rob_bank));
      check_val("wb.prf_we", 64'(wb.prf_we), 64'(e.prf_we));
      check_val("wb.prf_waddr", 64'(wb.prf_waddr), 64'(e.prf_waddr));
      check_val("wb.prf_wdata", 64'(wb.prf_wdata), 64'(e.prf_wdata));
      check_val("wb.fls", 64'(wb.fls), 64'(e.fls));
      check_val("wb.exc", 64'(wb.exc), 64'(e.exc));
      check_val("wb.opera", 64'(wb.opera), 64'(e.opera));
      check_val("wb.operb", 64'(wb.operb), 64'(e.operb));
      check_val("wb.fls_tgt", 64'(wb.fls_tgt), 64'(e.fls_tgt));
   endtask

   // Hold the request until the stage takes it
   task automatic send_req(input ex_req_t r);
      ex_valid = 1'b1;
      ex_req = r;
      @(negedge clk);
      while (!ex_ready) @(negedge clk);
      @(posedge clk);
      #0.5;
      ex_valid = 1'b0;
   endtask

   // wb_ready mode 0 high, 1 random, 2 low
   always @(posedge clk) begin
      #0.5;
      case (rdy_mode)
         2'd1:    wb_ready = 1'(take_bits(lfsr_rdy, 1));
         2'd2:    wb_ready = 1'b0;
         default: wb_ready = 1'b1;
      endcase
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT) begin
         stop_with_failure("run did not finish within the cycle limit");
      end
   end

   // Scoreboard, sampled mid-cycle where every signal is settled
   always @(negedge clk) begin
      if (!reset) begin
         if (acc_last) check_val("wb_valid", 64'(wb_valid), 64'd1);
         if (flush_last) check_val("wb_valid", 64'(wb_valid), 64'd0);
         if (hold_last) begin
            check_val("wb_valid", 64'(wb_valid), 64'd1);
            check_val("wb_held", 64'(wb == prev_wb), 64'd1);
         end
         if (wb_valid && wb_ready && !flush) begin
            if (exp_q.size() == 0) begin
               stop_with_failure("writeback record arrived with no request pending");
            end else begin
               compare_rec(exp_q.pop_front());
               n_done++;
            end
         end
         if (flush) begin
            n_drop += exp_q.size();
            exp_q.delete();
         end
         if (ex_valid && ex_ready) begin
            exp_q.push_back(ref_ex(ex_req));
            n_sent++;
         end
         acc_last = ex_valid && ex_ready;
         hold_last = wb_valid && !wb_ready && !flush;
         flush_last = flush;
         prev_wb = wb;
      end
   end

   initial begin
      reset = 1'b1;
      flush = 1'b0;
      ex_valid = 1'b0;
      ex_req = '0;
      wb_ready = 1'b0;
      rdy_mode = 2'd0;
      lfsr_req = SEED;
      lfsr_rdy = SEED;
      repeat (16) @(posedge clk);
      #0.5;
      reset = 1'b0;
      @(negedge clk);
      check_val("wb_valid", 64'(wb_valid), 64'd0);
      check_val("ex_ready", 64'(ex_ready), 64'd1);
      check_val("wb.prf_we", 64'(wb.prf_we), 64'd0);
      @(posedge clk);
      #0.5;
      for (int i = 0; i < N_A; i++) send_req(gen_req(lfsr_req));
      @(negedge clk);
      rdy_mode = 2'd1;
      @(posedge clk);
      #0.5;
      for (int i = 0; i < N_B; i++) send_req(gen_req(lfsr_req));
      // Drain the stalled stream so the flush cases start empty
      @(negedge clk);
      rdy_mode = 2'd0;
      while (exp_q.size() != 0) @(posedge clk);
      // One stalled record dropped by flush, then three that must arrive
      for (int i = 0; i < N_FL; i++) begin
         @(negedge clk);
         rdy_mode = 2'd2;
         @(posedge clk);
         #0.5;
         send_req(gen_req(lfsr_req));
         flush = 1'b1;
         @(posedge clk);
         #0.5;
         flush = 1'b0;
         @(negedge clk);
         rdy_mode = 2'd0;
         @(posedge clk);
         #0.5;
         repeat (3) send_req(gen_req(lfsr_req));
      end
      while (exp_q.size() != 0) @(posedge clk);
      repeat (2) @(posedge clk);
      if (n_sent == TOTAL && n_done + n_drop == n_sent && n_drop == N_FL) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         stop_with_failure("sent, compared and dropped record counts do not agree");
      end
   end

endmodule

// File: verilog.f
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_bru.sv
verilog/ex_hds_buf.sv
verilog/ex_pipe.sv
verification/tb_ex_pipe.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator.
# Exit status is nonzero when the build or the simulation fails.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
   echo "cannot enter project directory"
   exit 1
fi

verilator --binary --timing --assert \
   -f verilog.f \
   --top-module tb_ex_pipe \
   -Mdir obj_dir
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/Vtb_ex_pipe
status=$?
if [ $status -ne 0 ]; then
   echo "simulation failed with status $status"
   exit $status
fi

exit 0
